/* src/fd_params.svh */
`ifndef FD_PARAMS_SVH
`define FD_PARAMS_SVH

// ----------------------------------------
// stream geometry
// ----------------------------------------
`define FD_DATA_W 32
`define FD_KEEP_W 4

// ----------------------------------------
// egress ports and labels
// ----------------------------------------
`define FD_PORT_NUM 4
// label of port 0, following ports count up from here
`define FD_LABEL_BASE 1

// ----------------------------------------
// congestion marking
// ----------------------------------------
`define FD_FILL_W 32
`define FD_ALERT_THRESHOLD 32'd3000
`define FD_ECN_MARK 8'h01

// header is bytes 0..15, four beats of 32 bits
`define FD_HDR_BEATS 4

`endif

/* src/fd_stream_pkg.sv */
`include "fd_params.svh"

package fd_stream_pkg;

    // ----------------------------------------
    // axi-stream beat
    // ----------------------------------------

    // one bit per byte lane, byte 0 in bit 0
    typedef logic [`FD_KEEP_W-1:0] fd_keep_t;

    // byte 0 of a beat sits in data[7:0]
    typedef struct packed {
        logic [`FD_DATA_W-1:0] data;
        fd_keep_t              keep;
        logic                  last;
    } fd_beat_t;

endpackage

/* src/fd_header_pkg.sv */
`include "fd_params.svh"

package fd_header_pkg;

    // ----------------------------------------
    // switching types
    // ----------------------------------------

    typedef logic [7:0] fd_label_t;

    // one-hot, bit n drives egress port n
    typedef logic [`FD_PORT_NUM-1:0] fd_port_sel_t;

    // fill level per egress fifo, entry n for port n
    typedef logic [`FD_PORT_NUM-1:0][`FD_FILL_W-1:0] fd_port_fill_t;

    // ----------------------------------------
    // frame header, bytes 0..15
    // ----------------------------------------

    // mac fields keep wire order, byte 0 in the low bits
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] length_type;
        logic [7:0]  ecn;
        fd_label_t   label;
    } fd_header_t;

endpackage

/* src/fd_header_parser.sv */
`timescale 1ns/10ps
`include "fd_params.svh"

module fd_header_parser (
    input  logic                      glb_clk,
    input  logic                      glb_areset_n,
    input  fd_stream_pkg::fd_beat_t   s_axis_beat,
    input  logic                      s_axis_valid,
    output logic                      s_axis_ready,
    output fd_stream_pkg::fd_beat_t   p_beat,
    output logic                      p_valid,
    input  logic                      p_ready,
    output fd_header_pkg::fd_header_t hdr,
    output logic                      hdr_valid
);
    import fd_stream_pkg::*;

    localparam int CNT_W = $clog2(`FD_HDR_BEATS + 1);

    logic [CNT_W-1:0] beat_cnt;
    logic             rdy_en;
    logic             in_fire;
    fd_beat_t         beat_r;
    logic [47:0]      dst_mac_r;
    logic [47:0]      src_mac_r;

    // ----------------------------------------
    // input handshake
    // ----------------------------------------

    // register slot is free or drains this cycle
    assign s_axis_ready = rdy_en && (!p_valid || p_ready);
    assign in_fire      = s_axis_valid && s_axis_ready;

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            rdy_en   <= 1'b0;
            beat_cnt <= '0;
            p_valid  <= 1'b0;
        end else begin
            rdy_en <= 1'b1;
            if (in_fire) begin
                p_valid <= 1'b1;
                if (s_axis_beat.last) begin
                    beat_cnt <= '0;
                end else if (beat_cnt != CNT_W'(`FD_HDR_BEATS)) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end else if (p_ready) begin
                p_valid <= 1'b0;
            end
        end
    end

    // pipeline stage, payload only
    always_ff @(posedge glb_clk) begin
        if (in_fire) begin
            beat_r <= s_axis_beat;
        end
    end

    assign p_beat = beat_r;

    // ----------------------------------------
    // header capture
    // ----------------------------------------

    always_ff @(posedge glb_clk) begin
        if (in_fire) begin
            case (beat_cnt)
                CNT_W'(0): dst_mac_r[31:0] <= s_axis_beat.data;
                CNT_W'(1): begin
                    dst_mac_r[47:32] <= s_axis_beat.data[15:0];
                    src_mac_r[15:0]  <= s_axis_beat.data[31:16];
                end
                CNT_W'(2): src_mac_r[47:16] <= s_axis_beat.data;
                default: ;
            endcase
        end
    end

    // beat 3 fields come straight from the bus so the port map
    // can register its result on the same edge
    assign hdr.dst_mac     = dst_mac_r;
    assign hdr.src_mac     = src_mac_r;
    assign hdr.length_type = s_axis_beat.data[15:0];
    assign hdr.ecn         = s_axis_beat.data[23:16];
    assign hdr.label       = s_axis_beat.data[31:24];

    assign hdr_valid = in_fire && (beat_cnt == CNT_W'(`FD_HDR_BEATS - 1));

endmodule

/* src/fd_port_map.sv */
`timescale 1ns/10ps
`include "fd_params.svh"

module fd_port_map (
    input  logic                         glb_clk,
    input  logic                         glb_areset_n,
    input  fd_header_pkg::fd_header_t    hdr,
    input  logic                         hdr_valid,
    input  logic                         frame_done,
    input  fd_header_pkg::fd_port_fill_t port_fill,
    output fd_header_pkg::fd_port_sel_t  bus_sel,
    output logic [7:0]                   ecn_out
);
    import fd_header_pkg::*;

    fd_port_sel_t         sel_next;
    logic [`FD_FILL_W-1:0] fill_sel;
    logic [7:0]           ecn_next;

    // ----------------------------------------
    // label decode
    // ----------------------------------------

    // out of range labels leave both select and fill at zero
    always_comb begin
        sel_next = '0;
        fill_sel = '0;
        for (int i = 0; i < `FD_PORT_NUM; i++) begin
            if (hdr.label == fd_label_t'(`FD_LABEL_BASE + i)) begin
                sel_next[i] = 1'b1;
                fill_sel    = port_fill[i];
            end
        end
    end

    // congestion mark on the chosen port only
    assign ecn_next = (fill_sel > `FD_ALERT_THRESHOLD) ? `FD_ECN_MARK : hdr.ecn;

    // ----------------------------------------
    // per-frame registers
    // ----------------------------------------

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            bus_sel <= '0;
        end else if (hdr_valid) begin
            bus_sel <= sel_next;
        end else if (frame_done) begin
            bus_sel <= '0;
        end
    end

    always_ff @(posedge glb_clk) begin
        if (hdr_valid) begin
            ecn_out <= ecn_next;
        end
    end

endmodule

/* src/fd_frame_rewriter.sv */
`timescale 1ns/10ps
`include "fd_params.svh"

module fd_frame_rewriter (
    input  logic                    glb_clk,
    input  logic                    glb_areset_n,
    input  fd_stream_pkg::fd_beat_t p_beat,
    input  logic                    p_valid,
    output logic                    p_ready,
    input  logic [7:0]              ecn_out,
    output fd_stream_pkg::fd_beat_t m_axis_beat,
    output logic                    m_axis_valid,
    input  logic                    m_axis_ready,
    output logic                    frame_done
);
    import fd_stream_pkg::*;

    localparam int POS_W    = $clog2(`FD_HDR_BEATS + 1);
    localparam int CARRY_W  = `FD_DATA_W - 8;
    localparam int HDR_LAST = `FD_HDR_BEATS - 1;

    logic [POS_W-1:0]   pos;
    logic [CARRY_W-1:0] carry;
    logic               flush_pend;
    fd_keep_t           flush_keep;
    fd_beat_t           m_beat_r;
    fd_beat_t           out_next;
    logic               out_free;
    logic               p_fire;
    logic               load_out;
    logic               in_hdr;
    logic               in_label;
    logic               in_body;
    logic               needs_flush;

    // ----------------------------------------
    // handshake and position
    // ----------------------------------------

    assign out_free = !m_axis_valid || m_axis_ready;
    // flush beat owns the output slot for one cycle
    assign p_ready  = out_free && !flush_pend;
    assign p_fire   = p_valid && p_ready;

    assign in_hdr   = pos < POS_W'(HDR_LAST);
    assign in_label = pos == POS_W'(HDR_LAST);
    assign in_body  = pos == POS_W'(`FD_HDR_BEATS);

    // more than one byte in the tail leaves bytes in the carry
    assign needs_flush = p_beat.last && (p_beat.keep[`FD_KEEP_W-1:1] != '0);

    // ----------------------------------------
    // next output beat
    // ----------------------------------------

    always_comb begin
        load_out = 1'b0;
        out_next = m_beat_r;
        if (p_fire) begin
            if (in_hdr) begin
                load_out = 1'b1;
                out_next = p_beat;
            end else if (in_body) begin
                load_out      = 1'b1;
                out_next.data = {p_beat.data[7:0], carry};
                out_next.keep = '1;
                out_next.last = p_beat.last && !needs_flush;
            end
        end else if (flush_pend && out_free) begin
            load_out      = 1'b1;
            out_next.data = {8'h00, carry};
            out_next.keep = flush_keep;
            out_next.last = 1'b1;
        end
    end

    // ----------------------------------------
    // control state
    // ----------------------------------------

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            pos          <= '0;
            flush_pend   <= 1'b0;
            m_axis_valid <= 1'b0;
        end else begin
            if (p_fire) begin
                if (p_beat.last) begin
                    pos <= '0;
                end else if (!in_body) begin
                    pos <= pos + 1'b1;
                end
            end

            if (p_fire && in_body && needs_flush) begin
                flush_pend <= 1'b1;
            end else if (flush_pend && out_free) begin
                flush_pend <= 1'b0;
            end

            if (load_out) begin
                m_axis_valid <= 1'b1;
            end else if (m_axis_ready) begin
                m_axis_valid <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // payload
    // ----------------------------------------

    always_ff @(posedge glb_clk) begin
        if (load_out) begin
            m_beat_r <= out_next;
        end
        // label byte is dropped here, ecn replaced
        if (p_fire && in_label) begin
            carry <= {ecn_out, p_beat.data[15:0]};
        end else if (p_fire && in_body) begin
            carry <= p_beat.data[`FD_DATA_W-1:8];
        end
        if (p_fire && needs_flush) begin
            flush_keep <= fd_keep_t'(p_beat.keep >> 1);
        end
    end

    assign m_axis_beat = m_beat_r;
    assign frame_done  = m_axis_valid && m_axis_ready && m_beat_r.last;

endmodule

/* src/frame_decoder.sv */
`timescale 1ns/10ps

module frame_decoder (
    input  logic                         glb_clk,
    input  logic                         glb_areset_n,
    input  fd_stream_pkg::fd_beat_t      s_axis_beat,
    input  logic                         s_axis_valid,
    output logic                         s_axis_ready,
    output fd_stream_pkg::fd_beat_t      m_axis_beat,
    output logic                         m_axis_valid,
    input  logic                         m_axis_ready,
    input  fd_header_pkg::fd_port_fill_t port_fill,
    output fd_header_pkg::fd_port_sel_t  bus_sel
);
    import fd_stream_pkg::*;
    import fd_header_pkg::*;

    fd_beat_t   p_beat;
    logic       p_valid;
    logic       p_ready;
    fd_header_t hdr;
    logic       hdr_valid;
    logic       frame_done;
    logic [7:0] ecn_out;

    fd_header_parser fd_header_parser_inst (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_axis_beat  (s_axis_beat),
        .s_axis_valid (s_axis_valid),
        .s_axis_ready (s_axis_ready),
        .p_beat       (p_beat),
        .p_valid      (p_valid),
        .p_ready      (p_ready),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid)
    );

    fd_port_map fd_port_map_inst (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .frame_done   (frame_done),
        .port_fill    (port_fill),
        .bus_sel      (bus_sel),
        .ecn_out      (ecn_out)
    );

    fd_frame_rewriter fd_frame_rewriter_inst (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .p_beat       (p_beat),
        .p_valid      (p_valid),
        .p_ready      (p_ready),
        .ecn_out      (ecn_out),
        .m_axis_beat  (m_axis_beat),
        .m_axis_valid (m_axis_valid),
        .m_axis_ready (m_axis_ready),
        .frame_done   (frame_done)
    );

endmodule

/* tests/frame_decoder_assertions.sv */
`timescale 1ns/10ps

module frame_decoder_assertions (
    input  logic                        glb_clk,
    input  logic                        glb_areset_n,
    input  fd_stream_pkg::fd_beat_t     m_axis_beat,
    input  logic                        m_axis_valid,
    input  logic                        m_axis_ready,
    input  fd_header_pkg::fd_port_sel_t bus_sel
);

    // ----------------------------------------
    // output stream protocol
    // ----------------------------------------

    // stalled beat stays put
    stall_holds_beat: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        m_axis_valid && !m_axis_ready |=> m_axis_valid && $stable(m_axis_beat)
    ) else $error("output beat changed or vanished while the sink stalled");

    // keep grows from byte 0 with no holes
    keep_contiguous: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        m_axis_valid |-> (m_axis_beat.keep == 4'b0001 || m_axis_beat.keep == 4'b0011 ||
                          m_axis_beat.keep == 4'b0111 || m_axis_beat.keep == 4'b1111)
    ) else $error("output keep is not contiguous from byte 0");

    // partial keep only on the final beat
    keep_full_mid_frame: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        m_axis_valid && !m_axis_beat.last |-> m_axis_beat.keep == 4'b1111
    ) else $error("partial keep on a beat that is not the last one");

    // ----------------------------------------
    // port select
    // ----------------------------------------

    sel_one_hot: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        $onehot0(bus_sel)
    ) else $error("more than one egress port selected");

endmodule

/* tests/frame_decoder_tb.sv */
`timescale 1ns/10ps
`include "fd_params.svh"

module frame_decoder_tb;
    import fd_stream_pkg::*;
    import fd_header_pkg::*;

    localparam int          FRAME_NUM      = 200;
    localparam int          TIMEOUT_CYCLES = FRAME_NUM * 25 * 4;
    localparam logic [31:0] SEED           = 32'd72398;

    logic          glb_clk = 1'b0;
    logic          glb_areset_n;
    fd_beat_t      s_axis_beat;
    logic          s_axis_valid;
    logic          s_axis_ready;
    fd_beat_t      m_axis_beat;
    logic          m_axis_valid;
    logic          m_axis_ready;
    fd_port_fill_t port_fill;
    fd_port_sel_t  bus_sel;

    logic [31:0]   src_state   = SEED;
    logic [31:0]   snk_state   = SEED ^ 32'h9e37_79b9;
    logic          stim_on     = 1'b0;
    int            cycle_cnt   = 0;
    int            frames_rcvd = 0;
    int            out_pos     = 0;

    // expected output, filled as frames are sent
    logic [7:0]    exp_byte_q[$];
    int            exp_len_q[$];
    fd_port_sel_t  exp_sel_q[$];

    // in range labels twice as likely as the rest
    logic [7:0]    label_pool [12] = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h01, 8'h02,
                                       8'h03, 8'h04, 8'h00, 8'h05, 8'hfe, 8'hff};

    frame_decoder frame_decoder_inst (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_axis_beat  (s_axis_beat),
        .s_axis_valid (s_axis_valid),
        .s_axis_ready (s_axis_ready),
        .m_axis_beat  (m_axis_beat),
        .m_axis_valid (m_axis_valid),
        .m_axis_ready (m_axis_ready),
        .port_fill    (port_fill),
        .bus_sel      (bus_sel)
    );

    bind frame_decoder frame_decoder_assertions frame_decoder_assertions_inst (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .m_axis_beat  (m_axis_beat),
        .m_axis_valid (m_axis_valid),
        .m_axis_ready (m_axis_ready),
        .bus_sel      (bus_sel)
    );

    always #10 glb_clk = ~glb_clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_src();
        src_state = xorshift32(src_state);
        return src_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // ----------------------------------------
    // source side with reference model
    // ----------------------------------------

    task automatic send_frame();
        logic [7:0]    frame[$];
        fd_port_fill_t fill;
        fd_port_sel_t  sel_exp;
        fd_label_t     label;
        logic [7:0]    ecn_exp;
        logic [31:0]   r;
        fd_beat_t      beat;
        logic          accepted;
        int            len;
        int            idx;

        len = 17 + int'(next_src() % 32'd64);
        for (int i = 0; i < len; i++) begin
            r = next_src();
            frame.push_back(r[7:0]);
        end
        label     = label_pool[int'(next_src() % 32'd12)];
        frame[15] = label;
        // fills straddle the alert threshold
        for (int p = 0; p < `FD_PORT_NUM; p++) begin
            fill[p] = 32'd2997 + (next_src() % 32'd8);
        end

        sel_exp = '0;
        ecn_exp = frame[14];
        for (int p = 0; p < `FD_PORT_NUM; p++) begin
            if (label == fd_label_t'(`FD_LABEL_BASE + p)) begin
                sel_exp[p] = 1'b1;
                if (fill[p] > `FD_ALERT_THRESHOLD) begin
                    ecn_exp = `FD_ECN_MARK;
                end
            end
        end
        // label byte gone, everything after it moves down
        for (int i = 0; i < len; i++) begin
            if (i == 14) begin
                exp_byte_q.push_back(ecn_exp);
            end else if (i != 15) begin
                exp_byte_q.push_back(frame[i]);
            end
        end
        exp_len_q.push_back(len - 1);
        exp_sel_q.push_back(sel_exp);
        port_fill = fill;

        for (int b = 0; b * 4 < len; b++) begin
            while ((next_src() & 32'd3) == 32'd0) begin
                s_axis_valid = 1'b0;
                @(posedge glb_clk);
                #2;
            end
            for (int k = 0; k < 4; k++) begin
                idx = 4 * b + k;
                r   = next_src();
                if (idx < len) begin
                    beat.data[8*k +: 8] = frame[idx];
                    beat.keep[k]        = 1'b1;
                end else begin
                    beat.data[8*k +: 8] = r[7:0];
                    beat.keep[k]        = 1'b0;
                end
            end
            beat.last    = (4 * b + 4 >= len);
            s_axis_beat  = beat;
            s_axis_valid = 1'b1;
            accepted     = 1'b0;
            while (!accepted) begin
                @(negedge glb_clk);
                accepted = s_axis_ready;
                @(posedge glb_clk);
                #2;
            end
        end
    endtask

    initial begin : source_driver
        s_axis_beat  = '0;
        s_axis_valid = 1'b0;
        port_fill    = '0;
        wait (stim_on);
        for (int f = 0; f < FRAME_NUM; f++) begin
            send_frame();
        end
        s_axis_valid = 1'b0;
    end

    // random sink stalls, about one cycle in four
    initial begin : sink_driver
        m_axis_ready = 1'b0;
        wait (stim_on);
        forever begin
            @(posedge glb_clk);
            #2;
            snk_state    = xorshift32(snk_state);
            m_axis_ready = (snk_state[1:0] != 2'b00);
        end
    end

    // ----------------------------------------
    // output checking
    // ----------------------------------------

    task automatic check_out_beat();
        int         remain;
        int         nb;
        logic [3:0] exp_keep;
        logic       exp_last;

        assert (exp_len_q.size() > 0)
        else fail_run("output beat arrived when no frame was expected");
        remain   = exp_len_q[0] - out_pos;
        nb       = (remain > 4) ? 4 : remain;
        exp_keep = 4'((1 << nb) - 1);
        exp_last = (remain <= 4);
        check_value("m_axis_beat.keep", 32'(m_axis_beat.keep), 32'(exp_keep));
        check_value("m_axis_beat.last", 32'(m_axis_beat.last), 32'(exp_last));
        for (int k = 0; k < nb; k++) begin
            check_value($sformatf("m_axis_beat.data[%0d:%0d]", 8 * k + 7, 8 * k),
                        32'(m_axis_beat.data[8*k +: 8]), 32'(exp_byte_q.pop_front()));
        end
        // select is registered only after header beat 3
        if (out_pos >= 12) begin
            check_value("bus_sel", 32'(bus_sel), 32'(exp_sel_q[0]));
        end
        out_pos += nb;
        if (exp_last) begin
            void'(exp_len_q.pop_front());
            void'(exp_sel_q.pop_front());
            out_pos     = 0;
            frames_rcvd = frames_rcvd + 1;
        end
    endtask

    initial begin : output_monitor
        forever begin
            @(negedge glb_clk);
            if (glb_areset_n && m_axis_valid && m_axis_ready) begin
                check_out_beat();
            end
        end
    end

    always @(posedge glb_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run($sformatf("run did not finish within %0d cycles, %0d of %0d frames seen",
                               TIMEOUT_CYCLES, frames_rcvd, FRAME_NUM));
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin : main_sequence
        glb_areset_n = 1'b0;
        repeat (3) @(posedge glb_clk);
        #2;
        glb_areset_n = 1'b1;
        repeat (2) begin
            @(negedge glb_clk);
            check_value("m_axis_valid", 32'(m_axis_valid), 32'd0);
            check_value("bus_sel", 32'(bus_sel), 32'd0);
        end
        @(posedge glb_clk);
        #2;
        stim_on = 1'b1;
        wait (frames_rcvd == FRAME_NUM);
        // stray beats after the last frame would trip the monitor here
        repeat (20) @(posedge glb_clk);
        @(negedge glb_clk);
        // output drained and port released after the last frame
        check_value("m_axis_valid", 32'(m_axis_valid), 32'd0);
        check_value("bus_sel", 32'(bus_sel), 32'd0);
        $display("test passed");
        $finish;
    end

endmodule

/* frame_decoder.f */
+incdir+src
src/fd_stream_pkg.sv
src/fd_header_pkg.sv
src/fd_header_parser.sv
src/fd_port_map.sv
src/fd_frame_rewriter.sv
src/frame_decoder.sv
tests/frame_decoder_assertions.sv
tests/frame_decoder_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := frame_decoder_tb
FILELIST  := frame_decoder.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0 --Mdir $(BUILD_DIR)

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
